//--- include/cu_config.svh
// widths, compute unit ids and wait lengths shared by the design and its testbench
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// word and count widths
`define CU_WORD_BITS 64
`define VERTEX_BITS 32
`define EDGE_BITS 32
`define ADDR_BITS 64
`define CU_ID_BITS 8
`define OPCODE_BITS 3

// ids stamped on read commands and carried back in the responses
`define VERTEX_CONTROL_ID 8'hFE
`define ALGORITHM_ID 8'h01

// reset length and quiet window used by the testbench
`define RESET_CYCLES 5
`define HOLD_CYCLES 10

`endif

//--- hdl/cu_pkg.sv
// width typedefs plus the read opcode and arbiter owner enums
`include "cu_config.svh"

package cu_pkg;

	////////////////////////////////////////
	// data types
	////////////////////////////////////////

	// configuration and status words
	typedef logic [`CU_WORD_BITS-1:0] cu_word_t;

	// vertex and edge counts
	typedef logic [`VERTEX_BITS-1:0] vertex_count_t;
	typedef logic [`EDGE_BITS-1:0] edge_count_t;

	// compute unit id carried by commands and responses
	typedef logic [`CU_ID_BITS-1:0] cu_id_t;

	// read command address
	typedef logic [`ADDR_BITS-1:0] addr_t;

	////////////////////////////////////////
	// enums
	////////////////////////////////////////

	// cache line read flavours
	typedef enum logic [`OPCODE_BITS-1:0] {
		READ_CL_NA = 3'd1,
		READ_CL_S  = 3'd2,
		READ_CL_M  = 3'd3
	} read_opcode_e;

	// last winner of the read arbiter
	typedef enum logic {
		OWNER_VERTEX_JOB = 1'b0,
		OWNER_ALGORITHM  = 1'b1
	} arb_owner_e;

endpackage

//--- hdl/cu_input_stage.sv
// enable, configuration, descriptor and read response input registers with the ready level
`timescale 1ns/10ps

module cu_input_stage (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enable,
	input  cu_pkg::cu_word_t      cfg_var1,
	input  cu_pkg::cu_word_t      cfg_var3,
	input  cu_pkg::cu_word_t      cfg_var4,
	input  logic                  wed_valid,
	input  cu_pkg::vertex_count_t wed_num_vertices,
	input  cu_pkg::edge_count_t   wed_num_edges,
	input  logic                  resp_valid,
	input  cu_pkg::cu_id_t        resp_cu_id,
	input  logic                  resp_tag,
	output logic                  enabled,
	output logic                  cu_enabled,
	output cu_pkg::cu_word_t      cfg_status,
	output cu_pkg::vertex_count_t wed_num_vertices_q,
	output cu_pkg::edge_count_t   wed_num_edges_q,
	output logic                  resp_valid_q,
	output cu_pkg::cu_id_t        resp_cu_id_q,
	output logic                  resp_tag_q
);

	import cu_pkg::*;

	cu_word_t cfg_var1_q;
	cu_word_t cfg_var3_q;
	cu_word_t cfg_var4_q;
	logic     wed_valid_q;
	logic     cu_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable;
		end
	end

	////////////////////////////////////////
	// configuration words
	////////////////////////////////////////

	// zero writes are dropped so software can touch one word at a time
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_var1_q <= '0;
			cfg_var3_q <= '0;
			cfg_var4_q <= '0;
		end else if (enabled) begin
			if (|cfg_var1)
				cfg_var1_q <= cfg_var1;
			if (|cfg_var3)
				cfg_var3_q <= cfg_var3;
			if (|cfg_var4)
				cfg_var4_q <= cfg_var4;
		end
	end

	assign cfg_status = cfg_var1_q;

	////////////////////////////////////////
	// descriptor and responses
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_valid_q  <= 1'b0;
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= enabled & resp_valid;
			if (enabled)
				wed_valid_q <= wed_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			wed_num_vertices_q <= wed_num_vertices;
			wed_num_edges_q    <= wed_num_edges;
		end
		resp_cu_id_q <= resp_cu_id;
		resp_tag_q   <= resp_tag;
	end

	// ready once every word is set and a descriptor is present
	assign cu_ready = (|cfg_var1_q) & (|cfg_var3_q) & (|cfg_var4_q) & wed_valid_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_enabled <= 1'b0;
		end else begin
			cu_enabled <= cu_ready;
		end
	end

	ready_needs_cfg_a: assert property (@(posedge clock) disable iff (!rstn)
		cu_enabled |-> (cfg_var1_q != '0));

endmodule

//--- hdl/cu_response_router.sv
// read response routing to the vertex job path or the algorithm path by compute unit id
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_response_router (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  logic           resp_valid_q,
	input  cu_pkg::cu_id_t resp_cu_id_q,
	input  logic           resp_tag_q,
	output logic           vertex_resp_valid,
	output logic           vertex_resp_tag,
	output logic           algo_resp_valid,
	output logic           algo_resp_tag
);

	import cu_pkg::*;

	logic to_vertex;

	// only the vertex control id goes to the job path
	assign to_vertex = (resp_cu_id_q == cu_id_t'(`VERTEX_CONTROL_ID));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_resp_valid <= 1'b0;
			algo_resp_valid   <= 1'b0;
		end else if (enabled && resp_valid_q) begin
			vertex_resp_valid <= to_vertex;
			algo_resp_valid   <= ~to_vertex;
		end else begin
			vertex_resp_valid <= 1'b0;
			algo_resp_valid   <= 1'b0;
		end
	end

	// tag goes to both sides, the valids select
	always_ff @(posedge clock) begin
		vertex_resp_tag <= resp_tag_q;
		algo_resp_tag   <= resp_tag_q;
	end

	one_path_a: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_resp_valid && algo_resp_valid));

endmodule

//--- hdl/cu_read_arbiter.sv
// two-way round-robin read command arbiter with id tagging and almost-full hold-off
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_read_arbiter (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 cu_enabled,
	input  logic                 read_buf_alfull,
	input  logic                 vertex_req_valid,
	input  cu_pkg::read_opcode_e vertex_req_opcode,
	input  cu_pkg::addr_t        vertex_req_address,
	input  logic                 algo_req_valid,
	input  cu_pkg::read_opcode_e algo_req_opcode,
	input  cu_pkg::addr_t        algo_req_address,
	output logic                 vertex_req_grant,
	output logic                 algo_req_grant,
	output logic                 read_cmd_valid,
	output cu_pkg::read_opcode_e read_cmd_opcode,
	output cu_pkg::addr_t        read_cmd_address,
	output cu_pkg::cu_id_t       read_cmd_cu_id
);

	import cu_pkg::*;

	arb_owner_e owner;
	logic       eligible;
	logic       vertex_req;
	logic       algo_req;
	logic       grant_vertex;
	logic       grant_algo;

	////////////////////////////////////////
	// grant selection
	////////////////////////////////////////

	assign eligible = cu_enabled & ~read_buf_alfull;

	// mask the requester granted last cycle since its valid is still up
	assign vertex_req = vertex_req_valid & ~vertex_req_grant;
	assign algo_req   = algo_req_valid & ~algo_req_grant;

	// on a tie the side that did not win last goes first
	assign grant_vertex = eligible & vertex_req & (~algo_req | (owner == OWNER_ALGORITHM));
	assign grant_algo   = eligible & algo_req & (~vertex_req | (owner == OWNER_VERTEX_JOB));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_req_grant <= 1'b0;
			algo_req_grant   <= 1'b0;
			read_cmd_valid   <= 1'b0;
			owner            <= OWNER_ALGORITHM;
		end else begin
			vertex_req_grant <= grant_vertex;
			algo_req_grant   <= grant_algo;
			read_cmd_valid   <= grant_vertex | grant_algo;
			if (grant_vertex)
				owner <= OWNER_VERTEX_JOB;
			else if (grant_algo)
				owner <= OWNER_ALGORITHM;
		end
	end

	////////////////////////////////////////
	// command payload
	////////////////////////////////////////

	// stamp the winner's id so the response finds its way back
	always_ff @(posedge clock) begin
		if (grant_vertex) begin
			read_cmd_opcode  <= vertex_req_opcode;
			read_cmd_address <= vertex_req_address;
			read_cmd_cu_id   <= cu_id_t'(`VERTEX_CONTROL_ID);
		end else if (grant_algo) begin
			read_cmd_opcode  <= algo_req_opcode;
			read_cmd_address <= algo_req_address;
			read_cmd_cu_id   <= cu_id_t'(`ALGORITHM_ID);
		end
	end

	one_grant_a: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_req_grant && algo_req_grant));

	// grants are registered so the hold-off shows one cycle later
	alfull_hold_a: assert property (@(posedge clock) disable iff (!rstn)
		read_buf_alfull |=> !(vertex_req_grant || algo_req_grant));

endmodule

//--- hdl/cu_completion_tracker.sv
// vertex and edge count accumulation, done detection and return values
`timescale 1ns/10ps

module cu_completion_tracker (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  logic                  cu_enabled,
	input  cu_pkg::vertex_count_t wed_num_vertices_q,
	input  cu_pkg::edge_count_t   wed_num_edges_q,
	input  cu_pkg::cu_word_t      cfg_status,
	input  cu_pkg::vertex_count_t vertex_done_count,
	input  cu_pkg::vertex_count_t vertex_filtered_count,
	input  cu_pkg::edge_count_t   edge_done_count,
	output logic                  cu_done,
	output cu_pkg::cu_word_t      cu_status,
	output cu_pkg::vertex_count_t cu_return_vertices,
	output cu_pkg::edge_count_t   cu_return_edges
);

	import cu_pkg::*;

	vertex_count_t vertex_total_q;
	edge_count_t   edge_done_q;
	vertex_count_t return_vertices_q;
	edge_count_t   return_edges_q;
	logic          done_match;

	////////////////////////////////////////
	// step one, count capture
	////////////////////////////////////////

	// filtered vertices count as finished
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_total_q <= '0;
			edge_done_q    <= '0;
		end else if (enabled) begin
			vertex_total_q <= vertex_done_count + vertex_filtered_count;
			edge_done_q    <= edge_done_count;
		end
	end

	////////////////////////////////////////
	// step two, compare with descriptor
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done_match        <= 1'b0;
			return_vertices_q <= '0;
			return_edges_q    <= '0;
		end else if (cu_enabled) begin
			done_match        <= (vertex_total_q == wed_num_vertices_q) &&
			                     (edge_done_q == wed_num_edges_q);
			return_vertices_q <= vertex_total_q;
			return_edges_q    <= edge_done_q;
		end else begin
			done_match <= 1'b0;
		end
	end

	// step three drives the outputs
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_done            <= 1'b0;
			cu_status          <= '0;
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
		end else if (enabled) begin
			cu_done            <= done_match;
			cu_status          <= cfg_status;
			cu_return_vertices <= return_vertices_q;
			cu_return_edges    <= return_edges_q;
		end
	end

endmodule

//--- hdl/cu_control.sv
// compute unit control front end joining input stage, router, read arbiter and tracker
`timescale 1ns/10ps

module cu_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enable,
	input  cu_pkg::cu_word_t      cfg_var1,
	input  cu_pkg::cu_word_t      cfg_var3,
	input  cu_pkg::cu_word_t      cfg_var4,
	input  logic                  wed_valid,
	input  cu_pkg::vertex_count_t wed_num_vertices,
	input  cu_pkg::edge_count_t   wed_num_edges,
	input  logic                  resp_valid,
	input  cu_pkg::cu_id_t        resp_cu_id,
	input  logic                  resp_tag,
	input  logic                  vertex_req_valid,
	input  cu_pkg::read_opcode_e  vertex_req_opcode,
	input  cu_pkg::addr_t         vertex_req_address,
	input  logic                  algo_req_valid,
	input  cu_pkg::read_opcode_e  algo_req_opcode,
	input  cu_pkg::addr_t         algo_req_address,
	input  logic                  read_buf_alfull,
	input  cu_pkg::vertex_count_t vertex_done_count,
	input  cu_pkg::vertex_count_t vertex_filtered_count,
	input  cu_pkg::edge_count_t   edge_done_count,
	output logic                  vertex_resp_valid,
	output logic                  vertex_resp_tag,
	output logic                  algo_resp_valid,
	output logic                  algo_resp_tag,
	output logic                  vertex_req_grant,
	output logic                  algo_req_grant,
	output logic                  read_cmd_valid,
	output cu_pkg::read_opcode_e  read_cmd_opcode,
	output cu_pkg::addr_t         read_cmd_address,
	output cu_pkg::cu_id_t        read_cmd_cu_id,
	output logic                  cu_done,
	output cu_pkg::cu_word_t      cu_status,
	output cu_pkg::vertex_count_t cu_return_vertices,
	output cu_pkg::edge_count_t   cu_return_edges
);

	import cu_pkg::*;

	// latched state from the input stage
	logic          enabled;
	logic          cu_enabled;
	cu_word_t      cfg_status;
	vertex_count_t wed_num_vertices_q;
	edge_count_t   wed_num_edges_q;
	logic          resp_valid_q;
	cu_id_t        resp_cu_id_q;
	logic          resp_tag_q;

	////////////////////////////////////////
	// pipeline stages
	////////////////////////////////////////

	cu_input_stage input_stage (
		.clock              (clock),
		.rstn               (rstn),
		.enable             (enable),
		.cfg_var1           (cfg_var1),
		.cfg_var3           (cfg_var3),
		.cfg_var4           (cfg_var4),
		.wed_valid          (wed_valid),
		.wed_num_vertices   (wed_num_vertices),
		.wed_num_edges      (wed_num_edges),
		.resp_valid         (resp_valid),
		.resp_cu_id         (resp_cu_id),
		.resp_tag           (resp_tag),
		.enabled            (enabled),
		.cu_enabled         (cu_enabled),
		.cfg_status         (cfg_status),
		.wed_num_vertices_q (wed_num_vertices_q),
		.wed_num_edges_q    (wed_num_edges_q),
		.resp_valid_q       (resp_valid_q),
		.resp_cu_id_q       (resp_cu_id_q),
		.resp_tag_q         (resp_tag_q)
	);

	cu_response_router response_router (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.resp_valid_q      (resp_valid_q),
		.resp_cu_id_q      (resp_cu_id_q),
		.resp_tag_q        (resp_tag_q),
		.vertex_resp_valid (vertex_resp_valid),
		.vertex_resp_tag   (vertex_resp_tag),
		.algo_resp_valid   (algo_resp_valid),
		.algo_resp_tag     (algo_resp_tag)
	);

	cu_read_arbiter read_arbiter (
		.clock              (clock),
		.rstn               (rstn),
		.cu_enabled         (cu_enabled),
		.read_buf_alfull    (read_buf_alfull),
		.vertex_req_valid   (vertex_req_valid),
		.vertex_req_opcode  (vertex_req_opcode),
		.vertex_req_address (vertex_req_address),
		.algo_req_valid     (algo_req_valid),
		.algo_req_opcode    (algo_req_opcode),
		.algo_req_address   (algo_req_address),
		.vertex_req_grant   (vertex_req_grant),
		.algo_req_grant     (algo_req_grant),
		.read_cmd_valid     (read_cmd_valid),
		.read_cmd_opcode    (read_cmd_opcode),
		.read_cmd_address   (read_cmd_address),
		.read_cmd_cu_id     (read_cmd_cu_id)
	);

	cu_completion_tracker completion_tracker (
		.clock                 (clock),
		.rstn                  (rstn),
		.enabled               (enabled),
		.cu_enabled            (cu_enabled),
		.wed_num_vertices_q    (wed_num_vertices_q),
		.wed_num_edges_q       (wed_num_edges_q),
		.cfg_status            (cfg_status),
		.vertex_done_count     (vertex_done_count),
		.vertex_filtered_count (vertex_filtered_count),
		.edge_done_count       (edge_done_count),
		.cu_done               (cu_done),
		.cu_status             (cu_status),
		.cu_return_vertices    (cu_return_vertices),
		.cu_return_edges       (cu_return_edges)
	);

endmodule

//--- test/cu_control_tb.sv
// testbench for the compute unit control front end with row table, compare tasks and watchdog
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_control_tb;

	import cu_pkg::*;

	typedef enum logic [2:0] {
		ROW_CONFIG,
		ROW_RESPONSE,
		ROW_ARBITRATION,
		ROW_ALFULL,
		ROW_COMPLETION
	} row_kind_e;

	// one stimulus row with its expected results
	typedef struct packed {
		row_kind_e     kind;
		cu_word_t      cfg1;
		cu_word_t      cfg3;
		cu_word_t      cfg4;
		logic          wed_valid;
		cu_word_t      exp_status;
		logic          exp_grant;
		cu_id_t        resp_id;
		logic          resp_tag;
		logic          to_vertex;
		logic          vreq;
		logic          areq;
		read_opcode_e  vop;
		read_opcode_e  aop;
		addr_t         vaddr;
		addr_t         aaddr;
		vertex_count_t num_vertices;
		edge_count_t   num_edges;
		vertex_count_t done_count;
		vertex_count_t filtered_count;
		edge_count_t   edge_count;
		vertex_count_t exp_vertices;
		logic          exp_done;
	} row_t;

	logic          clock;
	logic          rstn;
	logic          enable;
	cu_word_t      cfg_var1;
	cu_word_t      cfg_var3;
	cu_word_t      cfg_var4;
	logic          wed_valid;
	vertex_count_t wed_num_vertices;
	edge_count_t   wed_num_edges;
	logic          resp_valid;
	cu_id_t        resp_cu_id;
	logic          resp_tag;
	logic          vertex_req_valid;
	read_opcode_e  vertex_req_opcode;
	addr_t         vertex_req_address;
	logic          algo_req_valid;
	read_opcode_e  algo_req_opcode;
	addr_t         algo_req_address;
	logic          read_buf_alfull;
	vertex_count_t vertex_done_count;
	vertex_count_t vertex_filtered_count;
	edge_count_t   edge_done_count;
	logic          vertex_resp_valid;
	logic          vertex_resp_tag;
	logic          algo_resp_valid;
	logic          algo_resp_tag;
	logic          vertex_req_grant;
	logic          algo_req_grant;
	logic          read_cmd_valid;
	read_opcode_e  read_cmd_opcode;
	addr_t         read_cmd_address;
	cu_id_t        read_cmd_cu_id;
	logic          cu_done;
	cu_word_t      cu_status;
	vertex_count_t cu_return_vertices;
	edge_count_t   cu_return_edges;

	row_t       rows[$];
	integer     seed = 93;
	int         cycles = 0;
	int         cycle_limit;
	arb_owner_e last_winner = OWNER_ALGORITHM;

	cu_control DUT (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// watchdog over the whole run
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$fatal(1, "watchdog expired");
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_word(input string name, input cu_word_t actual, input cu_word_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "word compare failed");
		end
	endtask

	task automatic check_count(input string name, input vertex_count_t actual,
		input vertex_count_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "count compare failed");
		end
	endtask

	task automatic check_address(input string name, input addr_t actual, input addr_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "address compare failed");
		end
	endtask

	task automatic check_cu_id(input string name, input cu_id_t actual, input cu_id_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "id compare failed");
		end
	endtask

	task automatic check_opcode(input string name, input read_opcode_e actual,
		input read_opcode_e expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "opcode compare failed");
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "bit compare failed");
		end
	endtask

	////////////////////////////////////////
	// table building
	////////////////////////////////////////

	task automatic config_entry(input cu_word_t c1, input cu_word_t c3, input cu_word_t c4,
		input logic wv, input cu_word_t status, input logic grant, input addr_t addr);
		row_t r;
		r = '0;
		r.kind = ROW_CONFIG;
		r.cfg1 = c1;
		r.cfg3 = c3;
		r.cfg4 = c4;
		r.wed_valid = wv;
		r.exp_status = status;
		r.exp_grant = grant;
		r.areq = 1'b1;
		r.aop = READ_CL_S;
		r.aaddr = addr;
		rows.push_back(r);
	endtask

	task automatic response_entry(input cu_id_t id, input logic tag, input logic to_vertex);
		row_t r;
		r = '0;
		r.kind = ROW_RESPONSE;
		r.resp_id = id;
		r.resp_tag = tag;
		r.to_vertex = to_vertex;
		rows.push_back(r);
	endtask

	task automatic arbitration_entry(input row_kind_e kind, input logic v, input logic a,
		input read_opcode_e vop, input read_opcode_e aop);
		row_t r;
		r = '0;
		r.kind = kind;
		r.vreq = v;
		r.areq = a;
		r.vop = vop;
		r.aop = aop;
		r.vaddr = {$random(seed), $random(seed)};
		r.aaddr = {$random(seed), $random(seed)};
		rows.push_back(r);
	endtask

	task automatic completion_entry(input vertex_count_t nv, input edge_count_t ne,
		input vertex_count_t dc, input vertex_count_t fc, input edge_count_t ec,
		input vertex_count_t total, input logic done);
		row_t r;
		r = '0;
		r.kind = ROW_COMPLETION;
		r.num_vertices = nv;
		r.num_edges = ne;
		r.done_count = dc;
		r.filtered_count = fc;
		r.edge_count = ec;
		r.exp_vertices = total;
		r.exp_done = done;
		rows.push_back(r);
	endtask

	task automatic build_table();
		addr_t cfg_addr;
		cfg_addr = {$random(seed), $random(seed)};
		// cu becomes ready only in the last of these rows
		config_entry(64'h11, 64'h0, 64'h0, 1'b0, 64'h11, 1'b0, cfg_addr);
		config_entry(64'h0, 64'h33, 64'h0, 1'b1, 64'h11, 1'b0, cfg_addr);
		config_entry(64'h21, 64'h0, 64'h44, 1'b0, 64'h21, 1'b0, cfg_addr);
		config_entry(64'h0, 64'h0, 64'h0, 1'b1, 64'h21, 1'b1, cfg_addr);
		response_entry(`VERTEX_CONTROL_ID, 1'b1, 1'b1);
		response_entry(`ALGORITHM_ID, 1'b0, 1'b0);
		response_entry(`VERTEX_CONTROL_ID, 1'b0, 1'b1);
		response_entry(8'h7C, 1'b1, 1'b0);
		arbitration_entry(ROW_ARBITRATION, 1'b1, 1'b1, READ_CL_NA, READ_CL_M);
		arbitration_entry(ROW_ARBITRATION, 1'b1, 1'b1, READ_CL_S, READ_CL_NA);
		arbitration_entry(ROW_ARBITRATION, 1'b0, 1'b1, READ_CL_NA, READ_CL_S);
		arbitration_entry(ROW_ARBITRATION, 1'b1, 1'b1, READ_CL_M, READ_CL_S);
		arbitration_entry(ROW_ARBITRATION, 1'b1, 1'b0, READ_CL_S, READ_CL_NA);
		arbitration_entry(ROW_ALFULL, 1'b1, 1'b1, READ_CL_M, READ_CL_NA);
		// filtered vertices count as finished
		completion_entry(32'd100, 32'd400, 32'd60, 32'd40, 32'd400, 32'd100, 1'b1);
		completion_entry(32'd100, 32'd400, 32'd60, 32'd30, 32'd400, 32'd90, 1'b0);
		completion_entry(32'd50, 32'd90, 32'd50, 32'd0, 32'd89, 32'd50, 1'b0);
		completion_entry(32'd7, 32'd9, 32'd3, 32'd4, 32'd9, 32'd7, 1'b1);
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic present_requests(input row_t r);
		vertex_req_valid = r.vreq;
		vertex_req_opcode = r.vop;
		vertex_req_address = r.vaddr;
		algo_req_valid = r.areq;
		algo_req_opcode = r.aop;
		algo_req_address = r.aaddr;
	endtask

	task automatic expect_no_grant(input int n);
		repeat (n) begin
			next_cycle();
			check_bit("vertex_req_grant", vertex_req_grant, 1'b0);
			check_bit("algo_req_grant", algo_req_grant, 1'b0);
			check_bit("read_cmd_valid", read_cmd_valid, 1'b0);
		end
	endtask

	// requesters drop valid right after their grant pulse
	task automatic collect_grants(input logic v_req, input logic a_req, input row_t r);
		logic vertex_pending;
		logic algo_pending;
		logic exp_vertex;
		vertex_pending = v_req;
		algo_pending = a_req;
		while (vertex_pending || algo_pending) begin
			next_cycle();
			if (vertex_req_grant || algo_req_grant) begin
				// on a tie the side that did not win last goes first
				if (vertex_pending && algo_pending)
					exp_vertex = (last_winner == OWNER_ALGORITHM);
				else
					exp_vertex = vertex_pending;
				check_bit("vertex_req_grant", vertex_req_grant, exp_vertex);
				check_bit("algo_req_grant", algo_req_grant, ~exp_vertex);
				check_bit("read_cmd_valid", read_cmd_valid, 1'b1);
				if (exp_vertex) begin
					check_opcode("read_cmd_opcode", read_cmd_opcode, r.vop);
					check_address("read_cmd_address", read_cmd_address, r.vaddr);
					check_cu_id("read_cmd_cu_id", read_cmd_cu_id, `VERTEX_CONTROL_ID);
					vertex_req_valid = 1'b0;
					vertex_pending = 1'b0;
					last_winner = OWNER_VERTEX_JOB;
				end else begin
					check_opcode("read_cmd_opcode", read_cmd_opcode, r.aop);
					check_address("read_cmd_address", read_cmd_address, r.aaddr);
					check_cu_id("read_cmd_cu_id", read_cmd_cu_id, `ALGORITHM_ID);
					algo_req_valid = 1'b0;
					algo_pending = 1'b0;
					last_winner = OWNER_ALGORITHM;
				end
			end else begin
				check_bit("read_cmd_valid", read_cmd_valid, 1'b0);
			end
		end
		// a served request is never granted again
		next_cycle();
		check_bit("vertex_req_grant", vertex_req_grant, 1'b0);
		check_bit("algo_req_grant", algo_req_grant, 1'b0);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int   i;
		row_t r;
		rstn = 1'b0;
		enable = 1'b0;
		cfg_var1 = '0;
		cfg_var3 = '0;
		cfg_var4 = '0;
		wed_valid = 1'b0;
		wed_num_vertices = '0;
		wed_num_edges = '0;
		resp_valid = 1'b0;
		resp_cu_id = '0;
		resp_tag = 1'b0;
		vertex_req_valid = 1'b0;
		vertex_req_opcode = READ_CL_NA;
		vertex_req_address = '0;
		algo_req_valid = 1'b0;
		algo_req_opcode = READ_CL_NA;
		algo_req_address = '0;
		read_buf_alfull = 1'b0;
		vertex_done_count = '0;
		vertex_filtered_count = '0;
		edge_done_count = '0;
		build_table();
		cycle_limit = rows.size() * 20 + `RESET_CYCLES;
		repeat (`RESET_CYCLES) @(posedge clock);
		#1;
		rstn = 1'b1;
		check_bit("read_cmd_valid", read_cmd_valid, 1'b0);
		check_bit("vertex_req_grant", vertex_req_grant, 1'b0);
		check_bit("algo_req_grant", algo_req_grant, 1'b0);
		check_bit("vertex_resp_valid", vertex_resp_valid, 1'b0);
		check_bit("algo_resp_valid", algo_resp_valid, 1'b0);
		check_bit("cu_done", cu_done, 1'b0);
		check_word("cu_status", cu_status, '0);
		enable = 1'b1;
		repeat (2) next_cycle();
		for (i = 0; i < rows.size(); i++) begin
			r = rows[i];
			case (r.kind)
				ROW_CONFIG: begin
					cfg_var1 = r.cfg1;
					cfg_var3 = r.cfg3;
					cfg_var4 = r.cfg4;
					wed_valid = r.wed_valid;
					present_requests(r);
					next_cycle();
					cfg_var1 = '0;
					cfg_var3 = '0;
					cfg_var4 = '0;
					if (r.exp_grant)
						collect_grants(1'b0, 1'b1, r);
					else
						expect_no_grant(`HOLD_CYCLES);
					check_word("cu_status", cu_status, r.exp_status);
				end
				ROW_RESPONSE: begin
					resp_valid = 1'b1;
					resp_cu_id = r.resp_id;
					resp_tag = r.resp_tag;
					next_cycle();
					resp_valid = 1'b0;
					check_bit("vertex_resp_valid", vertex_resp_valid, 1'b0);
					check_bit("algo_resp_valid", algo_resp_valid, 1'b0);
					next_cycle();
					check_bit("vertex_resp_valid", vertex_resp_valid, r.to_vertex);
					check_bit("algo_resp_valid", algo_resp_valid, ~r.to_vertex);
					if (r.to_vertex)
						check_bit("vertex_resp_tag", vertex_resp_tag, r.resp_tag);
					else
						check_bit("algo_resp_tag", algo_resp_tag, r.resp_tag);
				end
				ROW_ARBITRATION: begin
					present_requests(r);
					collect_grants(r.vreq, r.areq, r);
				end
				ROW_ALFULL: begin
					read_buf_alfull = 1'b1;
					present_requests(r);
					expect_no_grant(`HOLD_CYCLES);
					read_buf_alfull = 1'b0;
					collect_grants(r.vreq, r.areq, r);
				end
				ROW_COMPLETION: begin
					wed_num_vertices = r.num_vertices;
					wed_num_edges = r.num_edges;
					vertex_done_count = r.done_count;
					vertex_filtered_count = r.filtered_count;
					edge_done_count = r.edge_count;
					// three register steps before the new counts reach the outputs
					repeat (3) next_cycle();
					if (r.exp_done) begin
						while (cu_done !== 1'b1)
							next_cycle();
					end else begin
						repeat (`HOLD_CYCLES) begin
							check_bit("cu_done", cu_done, 1'b0);
							next_cycle();
						end
					end
					check_count("cu_return_vertices", cu_return_vertices, r.exp_vertices);
					check_count("cu_return_edges", cu_return_edges, r.edge_count);
				end
				default: begin
					$display("row %0d has an unknown kind", i);
					$display("TEST FAIL");
					$fatal(1, "bad table row");
				end
			endcase
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
hdl/cu_pkg.sv
hdl/cu_input_stage.sv
hdl/cu_response_router.sv
hdl/cu_read_arbiter.sv
hdl/cu_completion_tracker.sv
hdl/cu_control.sv
test/cu_control_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it, the exit status is the simulator's
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f compile.f \
	--top-module cu_control_tb \
	-Mdir obj_dir \
	-o cu_control_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit "$status"
fi

./obj_dir/cu_control_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
fi
exit "$status"
